/* Makefile */
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

# The simulation exits non-zero on a failed check, so the log decides
test:
	verilator --binary --timing --timescale 1ns/1ps -f all.f \
		--top-module tb_udp_echo -Mdir obj_dir -o sim_tb
	./obj_dir/sim_tb > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test completed successfully" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

/* all.f */
logic/udp_echo_pkg.sv
logic/payload_stream_if.sv
logic/udp_port_filter.sv
logic/payload_fifo.sv
logic/led_capture.sv
logic/udp_echo_top.sv
verif/tb_udp_echo.sv

/* logic/led_capture.sv */
module led_capture #(
    parameter int LED_WIDTH = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    input  udp_echo_pkg::data_t  data,
    input  logic                 valid,
    input  logic                 ready,
    input  logic                 last,
    output logic [LED_WIDTH-1:0] led
);

    logic xfer;
    logic in_frame;

    assign xfer = valid & ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            in_frame <= 1'b0;
            led      <= '0;
        end else if (xfer) begin
            // First beat of a frame, low bits of byte 0
            if (!in_frame) begin
                led <= data[LED_WIDTH-1:0];
            end
            // Single-beat frames never leave the idle state
            in_frame <= ~last;
        end
    end

endmodule

/* logic/payload_fifo.sv */
module payload_fifo #(
    parameter int ADDR_WIDTH = 10
) (
    input  logic            clk,
    input  logic            rst,
    payload_stream_if.sink   in,
    payload_stream_if.source out
);

    localparam int DEPTH      = 2 ** ADDR_WIDTH;
    localparam int DATA_BITS  = $bits(udp_echo_pkg::data_t);
    localparam int KEEP_BITS  = $bits(udp_echo_pkg::keep_t);
    localparam int WORD_WIDTH = DATA_BITS + KEEP_BITS + 2;

    typedef logic [WORD_WIDTH-1:0] word_t;
    typedef logic [ADDR_WIDTH:0]   ptr_t;

    word_t mem [DEPTH];

    ptr_t wr_ptr;
    ptr_t rd_ptr;

    word_t in_word;
    word_t out_word;
    logic  out_valid_q;

    logic full;
    logic empty;
    logic wr_en;
    logic out_free;
    logic rd_en;
    logic bypass;
    logic mem_wr;

    // Extra pointer bit separates full from empty
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[ADDR_WIDTH] != rd_ptr[ADDR_WIDTH]) &&
                   (wr_ptr[ADDR_WIDTH-1:0] == rd_ptr[ADDR_WIDTH-1:0]);

    assign in.ready = ~full;
    assign wr_en    = in.valid & ~full;

    // Output register can take a word this cycle
    assign out_free = ~out_valid_q | out.ready;
    assign rd_en    = out_free & ~empty;
    // Empty memory and free output register, word goes straight out
    assign bypass   = out_free & empty & wr_en;
    assign mem_wr   = wr_en & ~bypass;

    assign in_word = {in.last, in.user, in.keep, in.data};

    always_ff @(posedge clk) begin
        if (mem_wr) begin
            mem[wr_ptr[ADDR_WIDTH-1:0]] <= in_word;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (mem_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Output valid flag
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid_q <= 1'b0;
        end else if (rd_en || bypass) begin
            out_valid_q <= 1'b1;
        end else if (out.ready) begin
            out_valid_q <= 1'b0;
        end
    end

    // Output payload register, oldest stored word has priority
    always_ff @(posedge clk) begin
        if (rd_en) begin
            out_word <= mem[rd_ptr[ADDR_WIDTH-1:0]];
        end else if (bypass) begin
            out_word <= in_word;
        end
    end

    assign out.valid = out_valid_q;
    assign out.data  = out_word[DATA_BITS-1:0];
    assign out.keep  = out_word[DATA_BITS +: KEEP_BITS];
    assign out.user  = out_word[DATA_BITS + KEEP_BITS];
    assign out.last  = out_word[WORD_WIDTH-1];

endmodule

/* logic/payload_stream_if.sv */
interface payload_stream_if;

    udp_echo_pkg::data_t data;
    udp_echo_pkg::keep_t keep;
    logic                valid;
    logic                ready;
    logic                last;
    logic                user;

    // Producer side
    modport source (
        output data,
        output keep,
        output valid,
        output last,
        output user,
        input  ready
    );

    // Consumer side
    modport sink (
        input  data,
        input  keep,
        input  valid,
        input  last,
        input  user,
        output ready
    );

endinterface

/* logic/udp_echo_pkg.sv */
package udp_echo_pkg;

    // One beat of the payload stream
    typedef logic [63:0] data_t;

    // Byte enables, one per payload byte
    typedef logic [7:0] keep_t;

    // IPv4 address
    typedef logic [31:0] ip_addr_t;

    // UDP port number
    typedef logic [15:0] udp_port_t;

    // UDP length field, header plus payload in bytes
    typedef logic [15:0] udp_len_t;

    // IP time-to-live
    typedef logic [7:0] ttl_t;

    // Hop limit placed in every reply
    localparam ttl_t REPLY_TTL = 8'd64;

    // Frame disposition, held from the header handshake to the last payload beat
    typedef enum logic [1:0] {
        FILTER_IDLE    = 2'd0,
        FILTER_FORWARD = 2'd1,
        FILTER_DROP    = 2'd2
    } filter_state_t;

endpackage

/* logic/udp_echo_top.sv */
module udp_echo_top #(
    parameter udp_echo_pkg::udp_port_t ECHO_PORT       = 16'd1234,
    parameter udp_echo_pkg::ip_addr_t  LOCAL_IP        = {8'd192, 8'd168, 8'd1, 8'd128},
    parameter int                      FIFO_ADDR_WIDTH = 10,
    parameter int                      LED_WIDTH       = 4
) (
    input  logic                    clk,
    input  logic                    rst,

    // Received UDP header
    input  logic                    rx_hdr_valid,
    output logic                    rx_hdr_ready,
    input  udp_echo_pkg::ip_addr_t  rx_src_ip,
    input  udp_echo_pkg::udp_port_t rx_src_port,
    input  udp_echo_pkg::udp_port_t rx_dst_port,
    input  udp_echo_pkg::udp_len_t  rx_length,

    // Received payload
    input  udp_echo_pkg::data_t     rx_payload_data,
    input  udp_echo_pkg::keep_t     rx_payload_keep,
    input  logic                    rx_payload_valid,
    output logic                    rx_payload_ready,
    input  logic                    rx_payload_last,
    input  logic                    rx_payload_user,

    // Reply header
    output logic                    tx_hdr_valid,
    input  logic                    tx_hdr_ready,
    output udp_echo_pkg::ip_addr_t  tx_src_ip,
    output udp_echo_pkg::ip_addr_t  tx_dst_ip,
    output udp_echo_pkg::udp_port_t tx_src_port,
    output udp_echo_pkg::udp_port_t tx_dst_port,
    output udp_echo_pkg::udp_len_t  tx_length,
    output udp_echo_pkg::ttl_t      tx_ttl,
    output logic [5:0]              tx_dscp,
    output logic [1:0]              tx_ecn,

    // Reply payload
    output udp_echo_pkg::data_t     tx_payload_data,
    output udp_echo_pkg::keep_t     tx_payload_keep,
    output logic                    tx_payload_valid,
    input  logic                    tx_payload_ready,
    output logic                    tx_payload_last,
    output logic                    tx_payload_user,

    output logic [LED_WIDTH-1:0]    led
);

    payload_stream_if filt_to_fifo ();
    payload_stream_if fifo_to_out ();

    // Best effort service, no QoS marking
    assign tx_dscp = 6'd0;
    assign tx_ecn  = 2'd0;

    udp_port_filter #(
        .ECHO_PORT (ECHO_PORT),
        .LOCAL_IP  (LOCAL_IP)
    ) udp_port_filter_inst (
        .clk            (clk),
        .rst            (rst),
        .hdr_valid      (rx_hdr_valid),
        .hdr_ready      (rx_hdr_ready),
        .src_ip         (rx_src_ip),
        .src_port       (rx_src_port),
        .dst_port       (rx_dst_port),
        .length         (rx_length),
        .reply_valid    (tx_hdr_valid),
        .reply_ready    (tx_hdr_ready),
        .reply_src_ip   (tx_src_ip),
        .reply_dst_ip   (tx_dst_ip),
        .reply_src_port (tx_src_port),
        .reply_dst_port (tx_dst_port),
        .reply_length   (tx_length),
        .reply_ttl      (tx_ttl),
        .in_data        (rx_payload_data),
        .in_keep        (rx_payload_keep),
        .in_valid       (rx_payload_valid),
        .in_ready       (rx_payload_ready),
        .in_last        (rx_payload_last),
        .in_user        (rx_payload_user),
        .out            (filt_to_fifo.source)
    );

    payload_fifo #(
        .ADDR_WIDTH (FIFO_ADDR_WIDTH)
    ) payload_fifo_inst (
        .clk (clk),
        .rst (rst),
        .in  (filt_to_fifo.sink),
        .out (fifo_to_out.source)
    );

    // FIFO output fans out to the reply port and the LED tap
    assign tx_payload_data   = fifo_to_out.data;
    assign tx_payload_keep   = fifo_to_out.keep;
    assign tx_payload_valid  = fifo_to_out.valid;
    assign tx_payload_last   = fifo_to_out.last;
    assign tx_payload_user   = fifo_to_out.user;
    assign fifo_to_out.ready = tx_payload_ready;

    led_capture #(
        .LED_WIDTH (LED_WIDTH)
    ) led_capture_inst (
        .clk   (clk),
        .rst   (rst),
        .data  (fifo_to_out.data),
        .valid (fifo_to_out.valid),
        .ready (tx_payload_ready),
        .last  (fifo_to_out.last),
        .led   (led)
    );

endmodule

/* logic/udp_port_filter.sv */
module udp_port_filter #(
    parameter udp_echo_pkg::udp_port_t ECHO_PORT = 16'd1234,
    parameter udp_echo_pkg::ip_addr_t  LOCAL_IP  = {8'd192, 8'd168, 8'd1, 8'd128}
) (
    input  logic                    clk,
    input  logic                    rst,

    input  logic                    hdr_valid,
    output logic                    hdr_ready,
    input  udp_echo_pkg::ip_addr_t  src_ip,
    input  udp_echo_pkg::udp_port_t src_port,
    input  udp_echo_pkg::udp_port_t dst_port,
    input  udp_echo_pkg::udp_len_t  length,

    output logic                    reply_valid,
    input  logic                    reply_ready,
    output udp_echo_pkg::ip_addr_t  reply_src_ip,
    output udp_echo_pkg::ip_addr_t  reply_dst_ip,
    output udp_echo_pkg::udp_port_t reply_src_port,
    output udp_echo_pkg::udp_port_t reply_dst_port,
    output udp_echo_pkg::udp_len_t  reply_length,
    output udp_echo_pkg::ttl_t      reply_ttl,

    input  udp_echo_pkg::data_t     in_data,
    input  udp_echo_pkg::keep_t     in_keep,
    input  logic                    in_valid,
    output logic                    in_ready,
    input  logic                    in_last,
    input  logic                    in_user,

    payload_stream_if.source        out
);

    udp_echo_pkg::filter_state_t state;
    udp_echo_pkg::filter_state_t state_next;

    logic port_match;
    logic idle;
    logic hdr_xfer;
    logic last_xfer;

    assign port_match = (dst_port == ECHO_PORT);
    assign idle       = (state == udp_echo_pkg::FILTER_IDLE);

    // Reply header is offered only while no frame is in progress
    assign reply_valid = hdr_valid & port_match & idle;
    // Non-matching headers are swallowed without waiting on the reply side
    assign hdr_ready   = idle & (port_match ? reply_ready : 1'b1);
    assign hdr_xfer    = hdr_valid & hdr_ready;

    // Swap the endpoints for the answer
    assign reply_src_ip   = LOCAL_IP;
    assign reply_dst_ip   = src_ip;
    assign reply_src_port = dst_port;
    assign reply_dst_port = src_port;
    assign reply_length   = length;
    assign reply_ttl      = udp_echo_pkg::REPLY_TTL;

    // Payload gating by frame disposition
    always_comb begin
        case (state)
            udp_echo_pkg::FILTER_FORWARD: in_ready = out.ready;
            udp_echo_pkg::FILTER_DROP:    in_ready = 1'b1;
            default:                      in_ready = 1'b0;
        endcase
    end

    assign out.data  = in_data;
    assign out.keep  = in_keep;
    assign out.last  = in_last;
    assign out.user  = in_user;
    assign out.valid = in_valid & (state == udp_echo_pkg::FILTER_FORWARD);

    assign last_xfer = in_valid & in_ready & in_last;

    always_comb begin
        state_next = state;
        case (state)
            udp_echo_pkg::FILTER_IDLE: begin
                if (hdr_xfer) begin
                    state_next = port_match ? udp_echo_pkg::FILTER_FORWARD
                                            : udp_echo_pkg::FILTER_DROP;
                end
            end
            udp_echo_pkg::FILTER_FORWARD,
            udp_echo_pkg::FILTER_DROP: begin
                if (last_xfer) begin
                    state_next = udp_echo_pkg::FILTER_IDLE;
                end
            end
            default: begin
                state_next = udp_echo_pkg::FILTER_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= udp_echo_pkg::FILTER_IDLE;
        end else begin
            state <= state_next;
        end
    end

endmodule

/* verif/tb_udp_echo.sv */
module tb_udp_echo;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          NUM_FRAMES      = 40;
    localparam int          MAX_WORDS       = 40;
    localparam int          WATCHDOG_CYCLES = NUM_FRAMES * (MAX_WORDS + 20) * 4;
    localparam int          DRAIN_CYCLES    = 500;
    localparam logic [15:0] ECHO_PORT       = 16'd1234;
    localparam logic [31:0] LOCAL_IP        = {8'd192, 8'd168, 8'd1, 8'd128};

    logic        clk;
    logic        rst;
    logic        rx_hdr_valid;
    logic        rx_hdr_ready;
    logic [31:0] rx_src_ip;
    logic [15:0] rx_src_port;
    logic [15:0] rx_dst_port;
    logic [15:0] rx_length;
    logic [63:0] rx_payload_data;
    logic [7:0]  rx_payload_keep;
    logic        rx_payload_valid;
    logic        rx_payload_ready;
    logic        rx_payload_last;
    logic        rx_payload_user;
    logic        tx_hdr_valid;
    logic        tx_hdr_ready;
    logic [31:0] tx_src_ip;
    logic [31:0] tx_dst_ip;
    logic [15:0] tx_src_port;
    logic [15:0] tx_dst_port;
    logic [15:0] tx_length;
    logic [7:0]  tx_ttl;
    logic [5:0]  tx_dscp;
    logic [1:0]  tx_ecn;
    logic [63:0] tx_payload_data;
    logic [7:0]  tx_payload_keep;
    logic        tx_payload_valid;
    logic        tx_payload_ready;
    logic        tx_payload_last;
    logic        tx_payload_user;
    logic [3:0]  led;

    integer seed = 32'ha421_6023;

    // Reply headers as {src_ip, dst_ip, src_port, dst_port, length, ttl, dscp, ecn}
    logic [127:0] exp_hdrs [$];
    // Reply beats as {last, user, keep, data}
    logic [73:0]  exp_words [$];
    logic         tx_in_frame;
    logic [3:0]   led_expected;

    udp_echo_top #(
        .FIFO_ADDR_WIDTH (4)
    ) udp_echo_top_inst (
        .clk (clk), .rst (rst),
        .rx_hdr_valid (rx_hdr_valid), .rx_hdr_ready (rx_hdr_ready),
        .rx_src_ip (rx_src_ip), .rx_src_port (rx_src_port),
        .rx_dst_port (rx_dst_port), .rx_length (rx_length),
        .rx_payload_data (rx_payload_data), .rx_payload_keep (rx_payload_keep),
        .rx_payload_valid (rx_payload_valid), .rx_payload_ready (rx_payload_ready),
        .rx_payload_last (rx_payload_last), .rx_payload_user (rx_payload_user),
        .tx_hdr_valid (tx_hdr_valid), .tx_hdr_ready (tx_hdr_ready),
        .tx_src_ip (tx_src_ip), .tx_dst_ip (tx_dst_ip),
        .tx_src_port (tx_src_port), .tx_dst_port (tx_dst_port),
        .tx_length (tx_length), .tx_ttl (tx_ttl), .tx_dscp (tx_dscp), .tx_ecn (tx_ecn),
        .tx_payload_data (tx_payload_data), .tx_payload_keep (tx_payload_keep),
        .tx_payload_valid (tx_payload_valid), .tx_payload_ready (tx_payload_ready),
        .tx_payload_last (tx_payload_last), .tx_payload_user (tx_payload_user),
        .led (led)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Ports swapped, reply goes back to the sender from the local address
    function automatic logic [127:0] expected_reply(input logic [31:0] src_ip,
                                                    input logic [15:0] src_port,
                                                    input logic [15:0] dst_port,
                                                    input logic [15:0] length);
        return {LOCAL_IP, src_ip, dst_port, src_port, length, 8'd64, 6'd0, 2'd0};
    endfunction

    task automatic stop_with_error(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            stop_with_error($sformatf("mismatch at time %0t: %s is 0x%0h, expected 0x%0h",
                                      $time, name, actual, expected));
        end
    endtask

    task automatic check_idle_outputs();
        check_value("tx_payload_valid", 64'(tx_payload_valid), 64'd0);
        check_value("rx_payload_ready", 64'(rx_payload_ready), 64'd0);
        check_value("led", 64'(led), 64'd0);
    endtask

    // Called 2 ns after a rising edge, returns at the same phase
    task automatic send_frame(input logic match, input int nwords);
        logic [31:0] r;
        logic [31:0] src_ip;
        logic [15:0] src_port;
        logic [15:0] dst_port;
        logic [15:0] length;
        logic [63:0] data;
        int          i;
        src_ip   = $random(seed);
        r        = $random(seed);
        src_port = r[15:0];
        dst_port = match ? ECHO_PORT : r[31:16];
        if (!match && dst_port == ECHO_PORT) begin
            dst_port = ECHO_PORT ^ 16'd1;
        end
        length = 16'(8 + 8 * nwords);
        if (match) begin
            exp_hdrs.push_back(expected_reply(src_ip, src_port, dst_port, length));
        end
        rx_src_ip    = src_ip;
        rx_src_port  = src_port;
        rx_dst_port  = dst_port;
        rx_length    = length;
        rx_hdr_valid = 1'b1;
        @(posedge clk);
        while (!rx_hdr_ready) @(posedge clk);
        #2;
        rx_hdr_valid = 1'b0;
        for (i = 0; i < nwords; i++) begin
            data[63:32] = $random(seed);
            data[31:0]  = $random(seed);
            r           = $random(seed);
            if (match) begin
                exp_words.push_back({i == nwords - 1, r[8], r[7:0], data});
            end
            rx_payload_data  = data;
            rx_payload_keep  = r[7:0];
            rx_payload_user  = r[8];
            rx_payload_last  = (i == nwords - 1);
            rx_payload_valid = 1'b1;
            @(posedge clk);
            while (!rx_payload_ready) @(posedge clk);
            #2;
        end
        rx_payload_valid = 1'b0;
        rx_payload_last  = 1'b0;
    endtask

    // Random back-pressure on both reply channels, drawn at 1 ns, driven at 2 ns
    initial begin
        logic [31:0] r;
        tx_payload_ready = 1'b0;
        tx_hdr_ready     = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            r = $random(seed);
            #1;
            tx_payload_ready = r[0];
            tx_hdr_ready     = r[1] | r[2];
        end
    end

    // Reply comparator
    always @(posedge clk) begin
        logic [127:0] eh;
        logic [73:0]  ew;
        if (rst) begin
            tx_in_frame  = 1'b0;
            led_expected = 4'd0;
        end else begin
            // LEDs hold byte 0 of the latest echoed frame until the next one starts
            check_value("led", 64'(led), 64'(led_expected));
            if (tx_hdr_valid && tx_hdr_ready) begin
                if (exp_hdrs.size() == 0) begin
                    stop_with_error("reply header appeared with no echoed frame pending");
                end else begin
                    eh = exp_hdrs.pop_front();
                    check_value("tx_src_ip", 64'(tx_src_ip), 64'(eh[127:96]));
                    check_value("tx_dst_ip", 64'(tx_dst_ip), 64'(eh[95:64]));
                    check_value("tx_src_port", 64'(tx_src_port), 64'(eh[63:48]));
                    check_value("tx_dst_port", 64'(tx_dst_port), 64'(eh[47:32]));
                    check_value("tx_length", 64'(tx_length), 64'(eh[31:16]));
                    check_value("tx_ttl", 64'(tx_ttl), 64'(eh[15:8]));
                    check_value("tx_dscp", 64'(tx_dscp), 64'(eh[7:2]));
                    check_value("tx_ecn", 64'(tx_ecn), 64'(eh[1:0]));
                end
            end
            if (tx_payload_valid && tx_payload_ready) begin
                if (exp_words.size() == 0) begin
                    stop_with_error("reply payload appeared with no echoed word pending");
                end else begin
                    ew = exp_words.pop_front();
                    check_value("tx_payload_data", tx_payload_data, ew[63:0]);
                    check_value("tx_payload_keep", 64'(tx_payload_keep), 64'(ew[71:64]));
                    check_value("tx_payload_user", 64'(tx_payload_user), 64'(ew[72]));
                    check_value("tx_payload_last", 64'(tx_payload_last), 64'(ew[73]));
                    // LEDs take byte 0 of the first beat, visible from the next cycle
                    if (!tx_in_frame) begin
                        led_expected = ew[3:0];
                    end
                    tx_in_frame = !ew[73];
                end
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        stop_with_error($sformatf("timeout, the run did not finish within %0d cycles",
                                  WATCHDOG_CYCLES));
    end

    initial begin
        int          frame;
        int          nwords;
        int          drain;
        logic [31:0] r;
        rst              = 1'b1;
        rx_hdr_valid     = 1'b0;
        rx_src_ip        = '0;
        rx_src_port      = '0;
        rx_dst_port      = '0;
        rx_length        = '0;
        rx_payload_data  = '0;
        rx_payload_keep  = '0;
        rx_payload_valid = 1'b0;
        rx_payload_last  = 1'b0;
        rx_payload_user  = 1'b0;
        repeat (16) begin
            @(posedge clk);
            #1;
            check_idle_outputs();
        end
        #1;
        rst = 1'b0;
        repeat (4) begin
            @(posedge clk);
            #1;
            check_idle_outputs();
            #1;
        end
        // Two long frames first, one echoed and one dropped, then a random mix
        for (frame = 0; frame < NUM_FRAMES; frame++) begin
            r      = $random(seed);
            nwords = (frame < 2) ? MAX_WORDS : 1 + int'(r % 32'(MAX_WORDS));
            send_frame((frame == 0) ? 1'b1 : (frame == 1) ? 1'b0 : r[31], nwords);
        end
        // FIFO drains within a fixed number of cycles
        drain = 0;
        while ((exp_words.size() != 0 || exp_hdrs.size() != 0) && drain < DRAIN_CYCLES) begin
            @(posedge clk);
            drain++;
        end
        repeat (20) @(posedge clk);
        check_value("tx_payload_valid", 64'(tx_payload_valid), 64'd0);
        if (exp_words.size() == 0 && exp_hdrs.size() == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            stop_with_error("echoed words or headers are still outstanding at the end");
        end
    end

endmodule
